/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the state vector testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
    --top-module state_vector_tb -f state_vector.f \
    && ./obj_dir/Vstate_vector_tb | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }
grep -q "Done: no errors" sim.log && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

/* state_ctrl_mux.sv */
`default_nettype none

module state_ctrl_mux (
    input  logic       clk,
    input  logic       srst,
    state_if.target    dp_if,
    state_if.target    ctrl_if,
    state_if.requester out_if
);

    logic                  grant_dp;
    logic                  owner_dp;
    state_pkg::state_req_t dp_payload;
    state_pkg::state_req_t ctrl_payload;
    state_pkg::state_req_t out_payload;

    // ------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------
    // Datapath always wins when it asks
    assign grant_dp = dp_if.req;

    assign dp_payload   = '{id: dp_if.id, op: dp_if.op, len: dp_if.len};
    assign ctrl_payload = '{id: ctrl_if.id, op: ctrl_if.op, len: ctrl_if.len};
    assign out_payload  = grant_dp ? dp_payload : ctrl_payload;

    assign out_if.req = dp_if.req || ctrl_if.req;
    assign out_if.id  = out_payload.id;
    assign out_if.op  = out_payload.op;
    assign out_if.len = out_payload.len;

    // Control held off while datapath is requesting
    assign dp_if.rdy   = out_if.rdy;
    assign ctrl_if.rdy = out_if.rdy && !grant_dp;

    // ------------------------------------------------------------
    // Response side
    // ------------------------------------------------------------
    // Owner of the request in flight, ack comes back next cycle
    always_ff @(posedge clk) begin
        if (srst) begin
            owner_dp <= 1'b0;
        end else if (out_if.req && out_if.rdy) begin
            owner_dp <= grant_dp;
        end
    end

    assign dp_if.ack   = out_if.ack && owner_dp;
    assign ctrl_if.ack = out_if.ack && !owner_dp;

    // State only shows on the owning port
    assign dp_if.state   = owner_dp ? out_if.state : state_pkg::STATE_ZERO;
    assign ctrl_if.state = owner_dp ? state_pkg::STATE_ZERO : out_if.state;

    // One acceptance per cycle across both sides
    a_single_accept : assert property (@(posedge clk) disable iff (srst)
        !(dp_if.req && dp_if.rdy && ctrl_if.req && ctrl_if.rdy));

endmodule

`default_nettype wire

/* state_if.sv */
`default_nettype none

// Request/response channel
// Accept on req && rdy, ack is a single-cycle pulse with state
interface state_if;
    logic                 req;
    logic                 rdy;
    state_pkg::id_t       id;
    state_pkg::state_op_t op;
    state_pkg::len_t      len;
    logic                 ack;
    state_pkg::state_t    state;

    modport requester (
        output req, id, op, len,
        input  rdy, ack, state
    );

    modport target (
        input  req, id, op, len,
        output rdy, ack, state
    );
endinterface

// Table port between the RMW stage and the storage
interface state_tbl_if;
    logic              rd_en;
    state_pkg::id_t    rd_id;
    state_pkg::state_t rd_state;
    logic              wr_en;
    state_pkg::id_t    wr_id;
    state_pkg::state_t wr_state;

    modport rmw    (output rd_en, rd_id, wr_en, wr_id, wr_state, input  rd_state);
    modport memory (input  rd_en, rd_id, wr_en, wr_id, wr_state, output rd_state);
endinterface

`default_nettype wire

/* state_params.svh */
`ifndef STATE_PARAMS_SVH
`define STATE_PARAMS_SVH

// Flow ID width, sets the table depth
`define STATE_ID_BITS 6

// State fields
`define STATE_COUNT_BITS 16
`define STATE_TOTAL_BITS 20

// Length carried by each update
`define STATE_LEN_BITS 16

// One entry per flow ID
`define STATE_TABLE_DEPTH (1 << `STATE_ID_BITS)

`endif

/* state_pkg.sv */
`default_nettype none

`include "state_params.svh"

package state_pkg;

    // ------------------------------------------------------------
    // Field types
    // ------------------------------------------------------------
    typedef logic [`STATE_ID_BITS-1:0]    id_t;
    typedef logic [`STATE_LEN_BITS-1:0]   len_t;
    typedef logic [`STATE_COUNT_BITS-1:0] count_t;
    typedef logic [`STATE_TOTAL_BITS-1:0] total_t;

    // Operation applied to the stored state
    typedef enum logic [1:0] {
        OP_UPDATE = 2'd0,
        OP_INIT   = 2'd1,
        OP_READ   = 2'd2,
        OP_CLEAR  = 2'd3
    } state_op_t;

    // Stored per-flow state, 36 bits
    typedef struct packed {
        count_t count;
        total_t total;
    } state_t;

    // Request payload, 24 bits
    typedef struct packed {
        id_t       id;
        state_op_t op;
        len_t      len;
    } state_req_t;

    // ------------------------------------------------------------
    // Update rule constants
    // ------------------------------------------------------------
    localparam count_t COUNT_MAX  = '1;
    localparam total_t TOTAL_MAX  = '1;
    localparam count_t COUNT_INIT = count_t'(1);
    localparam state_t STATE_ZERO = '0;

endpackage

`default_nettype wire

/* state_rmw.sv */
`default_nettype none

module state_rmw (
    input  logic     clk,
    input  logic     srst,
    input  logic     init_done,
    state_if.target  req_if,
    state_tbl_if.rmw tbl
);

    localparam int SUM_BITS = $bits(state_pkg::total_t) + 1;

    logic                  accept;
    logic                  ctxt_vld;
    logic                  back_to_back;
    state_pkg::state_req_t ctxt;
    state_pkg::state_t     fwd_state;
    state_pkg::state_t     prev_state;
    state_pkg::state_t     next_state;
    logic [SUM_BITS-1:0]   total_sum;

    // ------------------------------------------------------------
    // Accept and read
    // ------------------------------------------------------------
    // Closed during the table sweep
    assign req_if.rdy = init_done;
    assign accept     = req_if.req && req_if.rdy;

    // Read goes out on the acceptance edge
    assign tbl.rd_en = accept;
    assign tbl.rd_id = req_if.id;

    // Request in the modify cycle
    always_ff @(posedge clk) begin
        if (srst) begin
            ctxt_vld <= 1'b0;
        end else begin
            ctxt_vld <= accept;
        end
    end

    // Context for the modify cycle
    // b2b when the previous edge also accepted this ID
    always_ff @(posedge clk) begin
        if (accept) begin
            ctxt         <= '{id: req_if.id, op: req_if.op, len: req_if.len};
            back_to_back <= ctxt_vld && (req_if.id == ctxt.id);
        end
    end

    // ------------------------------------------------------------
    // Modify
    // ------------------------------------------------------------
    // Table read is stale for b2b since its write lands on the read edge
    assign prev_state = back_to_back ? fwd_state : tbl.rd_state;

    always_comb begin
        total_sum  = {1'b0, prev_state.total} + SUM_BITS'(ctxt.len);
        next_state = prev_state;
        case (ctxt.op)
            state_pkg::OP_UPDATE: begin
                // Both fields stick at max
                if (prev_state.count != state_pkg::COUNT_MAX) begin
                    next_state.count = prev_state.count + 1'b1;
                end
                if (total_sum[SUM_BITS-1]) begin
                    next_state.total = state_pkg::TOTAL_MAX;
                end else begin
                    next_state.total = total_sum[SUM_BITS-2:0];
                end
            end
            state_pkg::OP_INIT: begin
                next_state.count = state_pkg::COUNT_INIT;
                next_state.total = state_pkg::total_t'(ctxt.len);
            end
            state_pkg::OP_READ: begin
                next_state = prev_state;
            end
            state_pkg::OP_CLEAR: begin
                next_state = state_pkg::STATE_ZERO;
            end
        endcase
    end

    // ------------------------------------------------------------
    // Write back and respond
    // ------------------------------------------------------------
    assign tbl.wr_en    = ctxt_vld;
    assign tbl.wr_id    = ctxt.id;
    assign tbl.wr_state = next_state;

    // Next-state copy for a b2b follower
    always_ff @(posedge clk) begin
        if (ctxt_vld) begin
            fwd_state <= next_state;
        end
    end

    // Response carries the state from before this request
    assign req_if.ack   = ctxt_vld;
    assign req_if.state = prev_state;

    // Ack and write-back of the accepted ID on the next edge
    a_ack_after_accept : assert property (@(posedge clk) disable iff (srst)
        accept |=> req_if.ack && tbl.wr_en && (tbl.wr_id == $past(req_if.id)));

endmodule

`default_nettype wire

/* state_table.sv */
`default_nettype none

`include "state_params.svh"

module state_table (
    input  logic        clk,
    input  logic        srst,
    state_tbl_if.memory tbl,
    output logic        init_done
);

    localparam int DEPTH = `STATE_TABLE_DEPTH;

    state_pkg::state_t mem [DEPTH];
    state_pkg::id_t    sweep_id;

    // ------------------------------------------------------------
    // Reset sweep
    // ------------------------------------------------------------
    // One entry per cycle, init_done on the last one
    always_ff @(posedge clk) begin
        if (srst) begin
            sweep_id  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            sweep_id <= sweep_id + 1'b1;
            if (sweep_id == state_pkg::id_t'(DEPTH - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------
    // Sweep owns the write port until done
    always_ff @(posedge clk) begin
        if (!init_done) begin
            mem[sweep_id] <= state_pkg::STATE_ZERO;
        end else if (tbl.wr_en) begin
            mem[tbl.wr_id] <= tbl.wr_state;
        end
    end

    // Registered read
    // same-edge write not seen, old value returned
    always_ff @(posedge clk) begin
        if (tbl.rd_en) begin
            tbl.rd_state <= mem[tbl.rd_id];
        end
    end

    // RMW stage must wait for the sweep
    a_no_early_write : assert property (@(posedge clk) disable iff (srst)
        tbl.wr_en |-> init_done);

endmodule

`default_nettype wire

/* state_vector.f */
+incdir+.
state_pkg.sv
state_if.sv
state_ctrl_mux.sv
state_table.sv
state_rmw.sv
state_vector_top.sv
tb_clk_gen.sv
state_vector_tb.sv

/* state_vector_tb.sv */
`default_nettype none

module state_vector_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 100;
    localparam int INIT_LIMIT = 200;

    logic                 clk;
    logic                 srst;
    logic                 init_done;
    logic                 dp_req;
    logic                 dp_rdy;
    state_pkg::id_t       dp_id;
    state_pkg::state_op_t dp_op;
    state_pkg::len_t      dp_len;
    logic                 dp_ack;
    state_pkg::state_t    dp_state;
    logic                 ctrl_req;
    logic                 ctrl_rdy;
    state_pkg::id_t       ctrl_id;
    state_pkg::state_op_t ctrl_op;
    state_pkg::len_t      ctrl_len;
    logic                 ctrl_ack;
    state_pkg::state_t    ctrl_state;

    // Trace contents, one entry per request line
    string                tr_name [$];
    int                   tr_line [$];
    bit                   tr_dp [$];
    bit                   tr_same [$];
    state_pkg::id_t       tr_id [$];
    state_pkg::state_op_t tr_op [$];
    state_pkg::len_t      tr_len [$];
    state_pkg::state_t    tr_exp [$];

    // Accepted requests awaiting ack, in acceptance order
    int pend_idx [$];
    int pend_edge [$];

    int cycle_count = 0;
    int value_errs = 0;
    int proto_errs = 0;
    int timeouts = 0;
    int load_errs = 0;

    tb_clk_gen u_clk_gen (.clk(clk), .srst(srst));

    state_vector_top u_dut (
        .clk(clk), .srst(srst), .init_done(init_done),
        .dp_req(dp_req), .dp_rdy(dp_rdy), .dp_id(dp_id), .dp_op(dp_op),
        .dp_len(dp_len), .dp_ack(dp_ack), .dp_state(dp_state),
        .ctrl_req(ctrl_req), .ctrl_rdy(ctrl_rdy), .ctrl_id(ctrl_id), .ctrl_op(ctrl_op),
        .ctrl_len(ctrl_len), .ctrl_ack(ctrl_ack), .ctrl_state(ctrl_state)
    );

    // Rising edges since time zero
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // ------------------------------------------------------------
    // Trace loading
    // ------------------------------------------------------------
    task automatic load_trace();
        int                fd;
        int                lineno;
        int                same_v;
        int                id_v;
        int                op_v;
        int                len_v;
        int                cnt_v;
        int                tot_v;
        logic [63:0]       name_tok;
        logic [63:0]       src_tok;
        string             text;
        state_pkg::state_t exp_v;
        fd = $fopen("state_vector_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open state_vector_trace.txt");
            load_errs++;
            return;
        end
        lineno = 0;
        while ($fgets(text, fd) != 0) begin
            lineno++;
            // Comment lines fail the match and are skipped
            if ($sscanf(text, "%s %s %d %h %d %h %h %h", name_tok, src_tok, same_v, id_v,
                        op_v, len_v, cnt_v, tot_v) == 8) begin
                exp_v.count = state_pkg::count_t'(cnt_v);
                exp_v.total = state_pkg::total_t'(tot_v);
                tr_name.push_back(string'(name_tok));
                tr_line.push_back(lineno);
                tr_dp.push_back(string'(src_tok) == "dp");
                tr_same.push_back(same_v != 0);
                tr_id.push_back(state_pkg::id_t'(id_v));
                tr_op.push_back(state_pkg::state_op_t'(op_v));
                tr_len.push_back(state_pkg::len_t'(len_v));
                tr_exp.push_back(exp_v);
            end
        end
        $fclose(fd);
        if (tr_id.size() == 0) begin
            $display("Trace file holds no request lines");
            load_errs++;
        end
    endtask

    // ------------------------------------------------------------
    // Driver
    // ------------------------------------------------------------
    // One or two lines presented together, held until each is accepted
    task automatic issue_group(input int first, input int count);
        int i;
        int dp_idx;
        int ctrl_idx;
        int waited;
        bit dp_pend;
        bit ctrl_pend;
        dp_pend   = 1'b0;
        ctrl_pend = 1'b0;
        dp_idx    = 0;
        ctrl_idx  = 0;
        for (i = first; i < first + count; i++) begin
            if (tr_dp[i]) begin
                dp_pend = 1'b1;
                dp_idx  = i;
            end else begin
                ctrl_pend = 1'b1;
                ctrl_idx  = i;
            end
        end
        waited = 0;
        while ((dp_pend || ctrl_pend) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            dp_req   <= dp_pend;
            dp_id    <= tr_id[dp_idx];
            dp_op    <= tr_op[dp_idx];
            dp_len   <= tr_len[dp_idx];
            ctrl_req <= ctrl_pend;
            ctrl_id  <= tr_id[ctrl_idx];
            ctrl_op  <= tr_op[ctrl_idx];
            ctrl_len <= tr_len[ctrl_idx];
            // rdy settled mid low phase, acceptance on the coming edge
            #1;
            assert (!(dp_pend && ctrl_rdy)) else begin
                $display("Control port ready while the datapath is requesting");
                proto_errs++;
            end
            if (dp_pend && dp_rdy) begin
                pend_idx.push_back(dp_idx);
                pend_edge.push_back(cycle_count + 1);
                dp_pend = 1'b0;
            end else if (ctrl_pend && ctrl_rdy) begin
                pend_idx.push_back(ctrl_idx);
                pend_edge.push_back(cycle_count + 1);
                ctrl_pend = 1'b0;
            end
            waited++;
        end
        if (dp_pend || ctrl_pend) begin
            $display("Timeout: request from trace line %0d was never accepted", tr_line[first]);
            timeouts++;
        end
    endtask

    // ------------------------------------------------------------
    // Response checker
    // ------------------------------------------------------------
    task automatic check_ack(input int idx);
        logic              own_ack;
        logic              other_ack;
        state_pkg::state_t got;
        own_ack   = tr_dp[idx] ? dp_ack : ctrl_ack;
        other_ack = tr_dp[idx] ? ctrl_ack : dp_ack;
        got       = tr_dp[idx] ? dp_state : ctrl_state;
        assert (own_ack && !other_ack) else begin
            $display("Ack for trace line %0d missing one cycle after acceptance or on wrong port",
                     tr_line[idx]);
            proto_errs++;
        end
        assert (got == tr_exp[idx]) else begin
            $display("ERROR %s line %0d: expected count=%h total=%h, actual count=%h total=%h",
                     tr_name[idx], tr_line[idx], tr_exp[idx].count, tr_exp[idx].total,
                     got.count, got.total);
            value_errs++;
        end
    endtask

    // Ack due in the cycle right after its acceptance edge
    always @(negedge clk) begin : check_responses
        int idx;
        if (pend_idx.size() != 0 && pend_edge[0] == cycle_count) begin
            idx = pend_idx.pop_front();
            void'(pend_edge.pop_front());
            check_ack(idx);
        end else begin
            assert (!dp_ack && !ctrl_ack) else begin
                $display("Ack in cycle %0d without an acceptance on the edge before",
                         cycle_count);
                proto_errs++;
            end
        end
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin : stimulus
        int i;
        int group;
        int waited;
        dp_req   = 1'b0;
        dp_id    = '0;
        dp_op    = state_pkg::OP_READ;
        dp_len   = '0;
        ctrl_req = 1'b0;
        ctrl_id  = '0;
        ctrl_op  = state_pkg::OP_READ;
        ctrl_len = '0;
        load_trace();

        // Sweep after reset, ports closed meanwhile
        waited = 0;
        while ((srst || !init_done) && waited < INIT_LIMIT) begin
            @(negedge clk);
            assert (init_done || (!dp_rdy && !ctrl_rdy)) else begin
                $display("Request port ready before the table sweep finished");
                proto_errs++;
            end
            waited++;
        end
        if (!init_done) begin
            $display("Timeout waiting for init_done after reset");
            timeouts++;
        end

        // Same-cycle flag pairs a line with the one before it
        i = 0;
        while (i < tr_id.size() && timeouts == 0) begin
            group = (i + 1 < tr_id.size() && tr_same[i + 1]) ? 2 : 1;
            issue_group(i, group);
            i += group;
        end

        // Drop both requests and drain the last acks
        @(negedge clk);
        dp_req   <= 1'b0;
        ctrl_req <= 1'b0;
        waited = 0;
        while (pend_idx.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (pend_idx.size() != 0) begin
            $display("Timeout: %0d accepted requests never got an ack", pend_idx.size());
            timeouts++;
        end

        $display("Summary: %0d value errors, %0d protocol errors, %0d timeouts, %0d load errors",
                 value_errs, proto_errs, timeouts, load_errs);
        if (value_errs + proto_errs + timeouts + load_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* state_vector_top.sv */
`default_nettype none

module state_vector_top (
    input  logic                 clk,
    input  logic                 srst,
    output logic                 init_done,

    // Datapath updates
    input  logic                 dp_req,
    output logic                 dp_rdy,
    input  state_pkg::id_t       dp_id,
    input  state_pkg::state_op_t dp_op,
    input  state_pkg::len_t      dp_len,
    output logic                 dp_ack,
    output state_pkg::state_t    dp_state,

    // Control plane reads and clears
    input  logic                 ctrl_req,
    output logic                 ctrl_rdy,
    input  state_pkg::id_t       ctrl_id,
    input  state_pkg::state_op_t ctrl_op,
    input  state_pkg::len_t      ctrl_len,
    output logic                 ctrl_ack,
    output state_pkg::state_t    ctrl_state
);

    state_if     dp_if ();
    state_if     ctrl_if ();
    state_if     mux_if ();
    state_tbl_if tbl_if ();

    // ------------------------------------------------------------
    // Port to interface
    // ------------------------------------------------------------
    assign dp_if.req = dp_req;
    assign dp_if.id  = dp_id;
    assign dp_if.op  = dp_op;
    assign dp_if.len = dp_len;
    assign dp_rdy    = dp_if.rdy;
    assign dp_ack    = dp_if.ack;
    assign dp_state  = dp_if.state;

    assign ctrl_if.req = ctrl_req;
    assign ctrl_if.id  = ctrl_id;
    assign ctrl_if.op  = ctrl_op;
    assign ctrl_if.len = ctrl_len;
    assign ctrl_rdy    = ctrl_if.rdy;
    assign ctrl_ack    = ctrl_if.ack;
    assign ctrl_state  = ctrl_if.state;

    // ------------------------------------------------------------
    // Arbiter, RMW stage, storage
    // ------------------------------------------------------------
    state_ctrl_mux u_mux (.clk(clk), .srst(srst), .dp_if(dp_if), .ctrl_if(ctrl_if),
                          .out_if(mux_if));

    state_rmw u_rmw (.clk(clk), .srst(srst), .init_done(init_done), .req_if(mux_if),
                     .tbl(tbl_if));

    state_table u_table (.clk(clk), .srst(srst), .tbl(tbl_if), .init_done(init_done));

endmodule

`default_nettype wire

/* state_vector_trace.txt */
# test src same id op len exp_count exp_total, all hex except same and op
# op 0 update 1 init 2 read 3 clear, same 1 rides with the line above on the other port
sweep ctrl 0 00 2 0000 0000 00000
sweep ctrl 0 15 2 0000 0000 00000
sweep ctrl 0 3f 2 0000 0000 00000
rule  dp   0 05 1 0100 0000 00000
rule  dp   0 05 0 0040 0001 00100
rule  dp   0 05 1 0010 0002 00140
rule  dp   0 05 0 0020 0001 00010
rule  ctrl 0 05 2 0000 0002 00030
rule  ctrl 0 05 3 0000 0002 00030
rule  ctrl 0 05 2 0000 0000 00000
sat   dp   0 09 1 ffff 0000 00000
sat   dp   0 09 0 ffff 0001 0ffff
sat   dp   0 09 0 ffff 0002 1fffe
sat   dp   0 09 0 ffff 0003 2fffd
sat   dp   0 09 0 ffff 0004 3fffc
sat   dp   0 09 0 ffff 0005 4fffb
sat   dp   0 09 0 ffff 0006 5fffa
sat   dp   0 09 0 ffff 0007 6fff9
sat   dp   0 09 0 ffff 0008 7fff8
sat   dp   0 09 0 ffff 0009 8fff7
sat   dp   0 09 0 ffff 000a 9fff6
sat   dp   0 09 0 ffff 000b afff5
sat   dp   0 09 0 ffff 000c bfff4
sat   dp   0 09 0 ffff 000d cfff3
sat   dp   0 09 0 ffff 000e dfff2
sat   dp   0 09 0 ffff 000f efff1
sat   dp   0 09 0 ffff 0010 ffff0
sat   dp   0 09 0 ffff 0011 fffff
sat   ctrl 0 09 2 0000 0012 fffff
fwd   dp   0 0a 1 0005 0000 00000
fwd   dp   0 0a 0 0003 0001 00005
fwd   dp   0 0b 1 0007 0000 00000
fwd   dp   0 0a 0 0001 0002 00008
fwd   dp   0 0a 0 0001 0003 00009
fwd   dp   0 0b 0 0002 0001 00007
prio  dp   0 0b 0 0010 0002 00009
prio  ctrl 1 0b 2 0000 0003 00019
prio  ctrl 0 0a 3 0000 0005 0000e
prio  dp   1 0a 0 0004 0004 0000a
prio  ctrl 0 0a 2 0000 0000 00000
prio  dp   0 05 1 0001 0000 00000
prio  ctrl 1 0b 2 0000 0003 00019

/* tb_clk_gen.sv */
`default_nettype none

// Free-running clock and power-on reset
module tb_clk_gen (
    output logic clk,
    output logic srst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held for 10 cycles, released on a falling edge
    initial begin
        srst = 1'b1;
        repeat (10) @(negedge clk);
        srst = 1'b0;
    end
endmodule

`default_nettype wire
